// ==== spi_slave_params.svh ====
`ifndef SPI_SLAVE_PARAMS_SVH
`define SPI_SLAVE_PARAMS_SVH

// ****************************************
// Word format and queue sizes
// ****************************************

// Bits per SPI word, MSB first on the wire
`define SPI_DATA_LEN 16

// Entries in each of the receive and transmit FIFOs
`define SPI_FIFO_DEPTH 4

// ****************************************
// Bus mode
// ****************************************

// Idle level of sclk
`define SPI_CPOL 0
// Zero samples on the leading edge, one samples on the trailing edge
`define SPI_CPHA 0
// Zero means chip-select is active low
`define SPI_INV_CS 0

// Reply sent whenever the transmit FIFO has nothing queued
`define SPI_DEFAULT_MISO 16'hCAFE

// APB register offsets
`define REG_STATUS 8'h00
`define REG_RXDATA 8'h04
`define REG_TXDATA 8'h08
`define REG_WORDS  8'h0C

`endif

// ==== rtl/spi_slave_pkg.sv ====
`include "spi_slave_params.svh"

package spi_slave_pkg;

  // One word as it appears on mosi or miso
  typedef logic [`SPI_DATA_LEN-1:0] spi_word_t;

  // Each pulse among the synchronized pin events lasts one clk cycle
  typedef struct packed {
    logic sample;
    logic shift;
    logic frame_start;
    logic frame_end;
    // Level that stays high for the whole frame
    logic active;
    logic mosi;
  } spi_evt_t;

  // Entry stored in the receive FIFO
  typedef struct packed {
    spi_word_t data;
  } rx_entry_t;

  // APB request from the host
  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [7:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  // APB response back to the host
  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // Overflow sits in bit 0 of the STATUS layout so a write of 1 clears it
  typedef struct packed {
    logic [2:0] rx_level;
    logic [2:0] tx_level;
    logic       rx_empty;
    logic       tx_full;
    logic       overflow;
  } status_t;

endpackage

// ==== rtl/spi_pin_sync.sv ====
`timescale 1ns/1ps

`include "spi_slave_params.svh"

module spi_pin_sync import spi_slave_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     sclk,
  input  logic     mosi,
  input  logic     cs,
  output spi_evt_t evt
);

  // Sampling happens on the rising edge for modes 0 and 3
  localparam bit   SAMPLE_RISE = (`SPI_CPOL == `SPI_CPHA);
  // Reset values match the idle bus so no edge is seen out of reset
  localparam logic SCLK_IDLE   = (`SPI_CPOL != 0);
  localparam logic CS_IDLE     = (`SPI_INV_CS == 0);

  logic [1:0] sclk_sync;
  logic [1:0] mosi_sync;
  logic [1:0] cs_sync;
  logic       sclk_prev;
  logic       cs_prev;
  logic       cs_act;
  logic       sclk_rise;
  logic       sclk_fall;
  logic       edge_evt;
  spi_evt_t   evt_q;

  // ****************************************
  // Two-flop synchronizers
  // ****************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sclk_sync <= {2{SCLK_IDLE}};
      mosi_sync <= '0;
      cs_sync   <= {2{CS_IDLE}};
    end else begin
      sclk_sync <= {sclk_sync[0], sclk};
      mosi_sync <= {mosi_sync[0], mosi};
      cs_sync   <= {cs_sync[0], cs};
    end
  end

  // Chip-select polarity is resolved after the synchronizer
  assign cs_act = (`SPI_INV_CS != 0) ? cs_sync[1] : ~cs_sync[1];

  assign sclk_rise = sclk_sync[1] & ~sclk_prev;
  assign sclk_fall = ~sclk_sync[1] & sclk_prev;

  // ****************************************
  // Edge register
  // ****************************************

  // The third stage makes events come out 3 clk cycles after the pins move
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      sclk_prev <= SCLK_IDLE;
      cs_prev   <= 1'b0;
      evt_q     <= '0;
    end else begin
      sclk_prev         <= sclk_sync[1];
      cs_prev           <= cs_act;
      // Clock edges outside a frame are ignored
      evt_q.sample      <= cs_act & (SAMPLE_RISE ? sclk_rise : sclk_fall);
      evt_q.shift       <= cs_act & (SAMPLE_RISE ? sclk_fall : sclk_rise);
      evt_q.frame_start <= cs_act & ~cs_prev;
      evt_q.frame_end   <= ~cs_act & cs_prev;
      evt_q.active      <= cs_act;
      // Delayed with the edge so it lines up with the sample pulse
      evt_q.mosi        <= mosi_sync[1];
    end
  end

  assign evt = evt_q;

  assign edge_evt = evt_q.sample || evt_q.shift;

  // An sclk half period of at least 3 clk cycles keeps edge pulses 3 cycles apart
  a_edge_spacing: assert property (
    @(posedge clk) disable iff (!arst_n) edge_evt |-> !$past(edge_evt) && !$past(edge_evt, 2)
  ) else $error("sclk edge events closer than 3 clk cycles");

endmodule

// ==== rtl/spi_word_shifter.sv ====
`timescale 1ns/1ps

`include "spi_slave_params.svh"

module spi_word_shifter import spi_slave_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  spi_evt_t  evt,
  input  spi_word_t tx_word,
  input  logic      tx_empty,
  input  logic      rx_full,
  output logic      miso,
  output logic      tx_pop,
  output logic      rx_push,
  output rx_entry_t rx_word,
  output logic      word_done,
  output logic      overflow
);

  localparam int               CNT_W    = $clog2(`SPI_DATA_LEN);
  localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(`SPI_DATA_LEN - 1);

  spi_word_t        tx_sr;
  spi_word_t        rx_sr;
  spi_word_t        next_reply;
  logic [CNT_W-1:0] bit_cnt;
  logic             last_sample;
  logic             load_reply;

  // ****************************************
  // Reply selection
  // ****************************************

  assign last_sample = evt.sample && (bit_cnt == LAST_BIT);

  // A new reply is needed when the frame opens and after every full word.
  // With CPHA=0 the slave cannot tell whether another word follows, so a
  // reply fetched on the last boundary of a frame is lost when cs drops
  assign load_reply = evt.frame_start || last_sample;
  assign tx_pop     = load_reply && !tx_empty;
  assign next_reply = tx_empty ? spi_word_t'(`SPI_DEFAULT_MISO) : tx_word;

  // The MSB goes out first and miso idles low because reset clears the register
  assign miso = tx_sr[`SPI_DATA_LEN-1];

  // ****************************************
  // Control and transmit shift register
  // ****************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      tx_sr     <= '0;
      bit_cnt   <= '0;
      rx_push   <= 1'b0;
      word_done <= 1'b0;
      overflow  <= 1'b0;
    end else begin
      rx_push   <= 1'b0;
      word_done <= 1'b0;
      overflow  <= 1'b0;
      if (evt.frame_end) begin
        // A partial word is simply dropped
        bit_cnt <= '0;
      end else if (evt.frame_start) begin
        bit_cnt <= '0;
        tx_sr   <= next_reply;
      end else if (evt.sample) begin
        bit_cnt <= bit_cnt + CNT_W'(1);
        if (last_sample) begin
          tx_sr     <= next_reply;
          word_done <= 1'b1;
          // Only this module pushes, so fullness cannot grow before the push lands
          rx_push   <= !rx_full;
          overflow  <= rx_full;
        end
      end else if (evt.shift && (bit_cnt != '0)) begin
        // The shift edge ahead of the first sample keeps the MSB in place
        tx_sr <= {tx_sr[`SPI_DATA_LEN-2:0], 1'b0};
      end
    end
  end

  // Receive shift register and the finished word handed to the FIFO
  always_ff @(posedge clk) begin
    if (evt.sample) begin
      rx_sr <= {rx_sr[`SPI_DATA_LEN-2:0], evt.mosi};
    end
    if (last_sample) begin
      rx_word.data <= {rx_sr[`SPI_DATA_LEN-2:0], evt.mosi};
    end
  end

  // The full flag seen at push time must still agree with the earlier decision
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!arst_n) rx_push |-> !rx_full
  ) else $error("rx_push while receive FIFO full");

endmodule

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/1ps

`include "spi_slave_params.svh"

module sync_fifo #(
  parameter type T     = logic [`SPI_DATA_LEN-1:0],
  parameter int  DEPTH = `SPI_FIFO_DEPTH
) (
  input  logic       clk,
  input  logic       arst_n,
  input  logic       push,
  input  T           wdata,
  input  logic       pop,
  output T           rdata,
  output logic       empty,
  output logic       full,
  output logic [2:0] level
);

  // One pointer bit is kept even for a single entry
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  T                 mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));
  assign level = 3'(count);

  // Head entry is visible without a read cycle
  assign rdata = mem[rd_ptr];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) wr_ptr <= ptr_next(wr_ptr);
      if (do_pop) rd_ptr <= ptr_next(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) mem[wr_ptr] <= wdata;
  end

  // Callers are expected to look at the flags before they act
  a_no_push_full: assert property (
    @(posedge clk) disable iff (!arst_n) push |-> !full
  ) else $error("push into full FIFO");

  a_no_pop_empty: assert property (
    @(posedge clk) disable iff (!arst_n) pop |-> !empty
  ) else $error("pop from empty FIFO");

endmodule

// ==== rtl/spi_apb_regs.sv ====
`timescale 1ns/1ps

`include "spi_slave_params.svh"

module spi_apb_regs import spi_slave_pkg::*; (
  input  logic       clk,
  input  logic       arst_n,
  input  apb_req_t   apb_req,
  input  rx_entry_t  rx_word,
  input  logic       rx_empty,
  input  logic [2:0] rx_level,
  input  logic       tx_full,
  input  logic [2:0] tx_level,
  input  logic       word_done,
  input  logic       overflow,
  output apb_rsp_t   apb_rsp,
  output logic       rx_pop,
  output logic       tx_push,
  output spi_word_t  tx_word
);

  logic        access;
  logic        rd_en;
  logic        wr_en;
  logic        sel_status;
  logic        sel_rx;
  logic        sel_tx;
  logic        sel_words;
  logic        bad_addr;
  logic        ovf_q;
  logic [15:0] words_q;
  status_t     status;

  // ****************************************
  // Access decode
  // ****************************************

  // Every access finishes in its first access cycle
  assign access = apb_req.psel && apb_req.penable;
  assign rd_en  = access && !apb_req.pwrite;
  assign wr_en  = access && apb_req.pwrite;

  always_comb begin
    sel_status = 1'b0;
    sel_rx     = 1'b0;
    sel_tx     = 1'b0;
    sel_words  = 1'b0;
    bad_addr   = 1'b0;
    case (apb_req.paddr)
      `REG_STATUS: sel_status = 1'b1;
      `REG_RXDATA: sel_rx     = 1'b1;
      `REG_TXDATA: sel_tx     = 1'b1;
      `REG_WORDS:  sel_words  = 1'b1;
      default:     bad_addr   = 1'b1;
    endcase
  end

  // FIFO strobes are held back on the error cases
  assign rx_pop  = rd_en && sel_rx && !rx_empty;
  assign tx_push = wr_en && sel_tx && !tx_full;
  assign tx_word = apb_req.pwdata[`SPI_DATA_LEN-1:0];

  assign status = '{
    rx_level: rx_level,
    tx_level: tx_level,
    rx_empty: rx_empty,
    tx_full:  tx_full,
    overflow: ovf_q
  };

  // ****************************************
  // Read data and response
  // ****************************************

  always_comb begin
    apb_rsp.pready  = 1'b1;
    apb_rsp.prdata  = '0;
    // TXDATA is write only and reads back as zero
    if (sel_status) apb_rsp.prdata = 32'(status);
    if (sel_rx) apb_rsp.prdata = 32'(rx_word.data);
    if (sel_words) apb_rsp.prdata = 32'(words_q);
    apb_rsp.pslverr = access && (bad_addr ||
                                 (rd_en && sel_rx && rx_empty) ||
                                 (wr_en && sel_tx && tx_full));
  end

  // ****************************************
  // Sticky overflow flag and word counter
  // ****************************************

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ovf_q   <= 1'b0;
      words_q <= '0;
    end else begin
      // A new overflow wins over a clear in the same cycle
      if (overflow) begin
        ovf_q <= 1'b1;
      end else if (wr_en && sel_status && apb_req.pwdata[0]) begin
        ovf_q <= 1'b0;
      end
      // Dropped words count too
      // A word that finishes during the clear is kept
      if (wr_en && sel_words) begin
        words_q <= word_done ? 16'd1 : 16'd0;
      end else if (word_done) begin
        words_q <= words_q + 16'd1;
      end
    end
  end

  // The access phase must be entered from a setup cycle with psel held
  a_penable_psel: assert property (
    @(posedge clk) disable iff (!arst_n) $rose(apb_req.penable) |-> apb_req.psel
  ) else $error("penable raised without psel");

endmodule

// ==== rtl/spi_slave_top.sv ====
`timescale 1ns/1ps

`include "spi_slave_params.svh"

module spi_slave_top import spi_slave_pkg::*; (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     sclk,
  input  logic     mosi,
  input  logic     cs,
  output logic     miso,
  input  apb_req_t apb_req,
  output apb_rsp_t apb_rsp
);

  spi_evt_t   evt;
  rx_entry_t  rx_in;
  rx_entry_t  rx_head;
  logic       rx_push;
  logic       rx_pop;
  logic       rx_empty;
  logic       rx_full;
  logic [2:0] rx_level;
  spi_word_t  tx_in;
  spi_word_t  tx_head;
  logic       tx_push;
  logic       tx_pop;
  logic       tx_empty;
  logic       tx_full;
  logic [2:0] tx_level;
  logic       word_done;
  logic       overflow;

  // ****************************************
  // SPI side
  // ****************************************

  spi_pin_sync pin_sync0 (
    .clk    (clk),
    .arst_n (arst_n),
    .sclk   (sclk),
    .mosi   (mosi),
    .cs     (cs),
    .evt    (evt)
  );

  spi_word_shifter shifter0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .evt       (evt),
    .tx_word   (tx_head),
    .tx_empty  (tx_empty),
    .rx_full   (rx_full),
    .miso      (miso),
    .tx_pop    (tx_pop),
    .rx_push   (rx_push),
    .rx_word   (rx_in),
    .word_done (word_done),
    .overflow  (overflow)
  );

  // Received words waiting for the host
  sync_fifo #(.T(rx_entry_t), .DEPTH(`SPI_FIFO_DEPTH)) rx_fifo0 (
    .clk (clk), .arst_n (arst_n),
    .push (rx_push), .wdata (rx_in), .pop (rx_pop), .rdata (rx_head),
    .empty (rx_empty), .full (rx_full), .level (rx_level)
  );

  // Replies queued by the host
  sync_fifo #(.T(spi_word_t), .DEPTH(`SPI_FIFO_DEPTH)) tx_fifo0 (
    .clk (clk), .arst_n (arst_n),
    .push (tx_push), .wdata (tx_in), .pop (tx_pop), .rdata (tx_head),
    .empty (tx_empty), .full (tx_full), .level (tx_level)
  );

  // ****************************************
  // Host side
  // ****************************************

  spi_apb_regs regs0 (
    .clk       (clk),
    .arst_n    (arst_n),
    .apb_req   (apb_req),
    .rx_word   (rx_head),
    .rx_empty  (rx_empty),
    .rx_level  (rx_level),
    .tx_full   (tx_full),
    .tx_level  (tx_level),
    .word_done (word_done),
    .overflow  (overflow),
    .apb_rsp   (apb_rsp),
    .rx_pop    (rx_pop),
    .tx_push   (tx_push),
    .tx_word   (tx_in)
  );

endmodule

// ==== verification/tb_spi_slave.sv ====
`timescale 1ns/1ps

`include "spi_slave_params.svh"

module tb_spi_slave import spi_slave_pkg::*; ();

  localparam int   W          = `SPI_DATA_LEN;
  // Clk cycles per sclk half period
  localparam int   HALF       = 4;
  localparam int   APB_LIMIT  = 16;
  localparam int   POLL_LIMIT = 200;
  localparam logic SCLK_IDLE  = (`SPI_CPOL != 0);
  localparam logic CS_ON      = (`SPI_INV_CS != 0);

  logic        clk;
  logic        arst_n;
  logic        sclk;
  logic        mosi;
  logic        cs;
  logic        miso;
  apb_req_t    apb_req;
  apb_rsp_t    apb_rsp;
  logic [31:0] rng_state;
  logic [15:0] words_exp;
  // Words the SPI master sends, and the replies it collects
  spi_word_t   mosi_words[$];
  spi_word_t   miso_words[$];

  spi_slave_top dut0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .sclk    (sclk),
    .mosi    (mosi),
    .cs      (cs),
    .miso    (miso),
    .apb_req (apb_req),
    .apb_rsp (apb_rsp)
  );

  always #20 clk = ~clk;

  // ****************************************
  // Compare tasks and random data
  // ****************************************

  task automatic check_word(input string name, input spi_word_t exp, input spi_word_t act);
    if (act !== exp) begin
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1, "word mismatch on %s", name);
    end
  endtask

  task automatic check_status(input string name, input status_t exp, input status_t act);
    if (act !== exp) begin
      $display("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act);
      $display("Test failed");
      $fatal(1, "status mismatch on %s", name);
    end
  endtask

  task automatic check_err(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL time=%0t %s expected=%b actual=%b", $time, name, exp, act);
      $display("Test failed");
      $fatal(1, "error flag mismatch on %s", name);
    end
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR at %0t: timed out, %s", $time, what);
    $display("Test failed");
    $fatal(1, "timeout");
  endtask

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic draw_word(output spi_word_t w);
    rng_state = xorshift32(rng_state);
    w = rng_state[W-1:0];
  endtask

  function automatic status_t status_of(input logic [31:0] d);
    return status_t'(d[$bits(status_t)-1:0]);
  endfunction

  // ****************************************
  // APB driver
  // ****************************************

  // A setup cycle is followed by an access cycle that lasts until pready
  // The response is taken on the falling edge where it is stable
  task automatic bus_cycle(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output logic err);
    int waited;
    waited = 0;
    @(posedge clk);
    apb_req <= '{psel: 1'b1, penable: 1'b0, pwrite: write, paddr: addr, pwdata: wdata};
    @(posedge clk);
    apb_req.penable <= 1'b1;
    @(negedge clk);
    while (!apb_rsp.pready && waited < APB_LIMIT) begin
      waited++;
      @(negedge clk);
    end
    if (!apb_rsp.pready) begin
      report_timeout("APB pready stayed low");
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    @(posedge clk);
    apb_req <= '0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] data, output logic err);
    logic [31:0] unused;
    bus_cycle(1'b1, addr, data, unused, err);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] data, output logic err);
    bus_cycle(1'b0, addr, 32'h0, data, err);
  endtask

  // Accesses that must complete without an error response
  task automatic read_reg(input logic [7:0] addr, output logic [31:0] data);
    logic err;
    apb_read(addr, data, err);
    check_err($sformatf("pslverr read 0x%h", addr), 1'b0, err);
  endtask

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data);
    logic err;
    apb_write(addr, data, err);
    check_err($sformatf("pslverr write 0x%h", addr), 1'b0, err);
  endtask

  task automatic compare_word_count();
    logic [31:0] data;
    read_reg(`REG_WORDS, data);
    check_word("WORDS", words_exp, data[15:0]);
  endtask

  // Polls STATUS until the receive FIFO holds the given number of words
  task automatic wait_rx_level(input logic [2:0] level);
    logic [31:0] data;
    status_t     st;
    int          polls;
    polls = 0;
    read_reg(`REG_STATUS, data);
    st = status_of(data);
    while (st.rx_level != level && polls < POLL_LIMIT) begin
      polls++;
      read_reg(`REG_STATUS, data);
      st = status_of(data);
    end
    if (st.rx_level != level) begin
      report_timeout($sformatf("receive level %0d never reached", level));
    end
  endtask

  // ****************************************
  // SPI master
  // ****************************************

  // Sends nbits from mosi_words MSB first in one frame. The slave moves miso
  // 4 clk cycles after the shifting edge, so each bit is collected late in
  // the phase that follows the sampling edge
  task automatic spi_transfer(input int nbits);
    spi_word_t cur;
    spi_word_t rx_word;
    int        k;
    rx_word = '0;
    cur     = mosi_words[0];
    miso_words.delete();
    @(posedge clk);
    cs   <= CS_ON;
    mosi <= cur[W-1];
    // Lead-in gives the slave time to load its first reply
    repeat (HALF) @(posedge clk);
    for (k = 0; k < nbits; k++) begin
      sclk <= ~SCLK_IDLE;
      repeat (HALF - 1) @(posedge clk);
      @(negedge clk);
      rx_word = {rx_word[W-2:0], miso};
      if (k % W == W - 1) miso_words.push_back(rx_word);
      @(posedge clk);
      sclk <= SCLK_IDLE;
      if (k + 1 < nbits) begin
        if ((k + 1) % W == 0) cur = mosi_words[(k + 1) / W];
        else cur = cur << 1;
        mosi <= cur[W-1];
      end
      repeat (HALF) @(posedge clk);
    end
    cs <= ~CS_ON;
    // Idle time between frames
    repeat (2 * HALF) @(posedge clk);
  endtask

  // ****************************************
  // Directed tests
  // ****************************************

  task automatic reset_values();
    logic [31:0] data;
    read_reg(`REG_STATUS, data);
    check_status("STATUS", '{3'd0, 3'd0, 1'b1, 1'b0, 1'b0}, status_of(data));
    compare_word_count();
  endtask

  task automatic default_reply();
    spi_word_t   w;
    logic [31:0] data;
    draw_word(w);
    mosi_words.delete();
    mosi_words.push_back(w);
    spi_transfer(W);
    check_word("miso word 0", `SPI_DEFAULT_MISO, miso_words[0]);
    wait_rx_level(3'd1);
    read_reg(`REG_RXDATA, data);
    check_word("RXDATA", w, data[15:0]);
    words_exp = words_exp + 16'd1;
    compare_word_count();
  endtask

  // The default follows the three queued replies once the TX FIFO runs dry
  task automatic queued_replies();
    spi_word_t   replies[$];
    spi_word_t   w;
    logic [31:0] data;
    int          i;
    mosi_words.delete();
    for (i = 0; i < 3; i++) begin
      draw_word(w);
      replies.push_back(w);
      write_reg(`REG_TXDATA, {16'h0, w});
    end
    replies.push_back(`SPI_DEFAULT_MISO);
    for (i = 0; i < 4; i++) begin
      draw_word(w);
      mosi_words.push_back(w);
    end
    spi_transfer(4 * W);
    for (i = 0; i < 4; i++) check_word($sformatf("miso word %0d", i), replies[i], miso_words[i]);
    wait_rx_level(3'd4);
    for (i = 0; i < 4; i++) begin
      read_reg(`REG_RXDATA, data);
      check_word($sformatf("RXDATA %0d", i), mosi_words[i], data[15:0]);
    end
    words_exp = words_exp + 16'd4;
    compare_word_count();
  endtask

  task automatic overflow_drop();
    spi_word_t   w;
    logic [31:0] data;
    int          i;
    mosi_words.delete();
    for (i = 0; i < 5; i++) begin
      draw_word(w);
      mosi_words.push_back(w);
    end
    spi_transfer(5 * W);
    wait_rx_level(3'd4);
    read_reg(`REG_STATUS, data);
    check_status("STATUS overflow", '{3'd4, 3'd0, 1'b0, 1'b0, 1'b1}, status_of(data));
    for (i = 0; i < 4; i++) begin
      read_reg(`REG_RXDATA, data);
      check_word($sformatf("RXDATA %0d", i), mosi_words[i], data[15:0]);
    end
    write_reg(`REG_STATUS, 32'h1);
    read_reg(`REG_STATUS, data);
    check_status("STATUS cleared", '{3'd0, 3'd0, 1'b1, 1'b0, 1'b0}, status_of(data));
    // The dropped fifth word is still counted
    words_exp = words_exp + 16'd5;
    compare_word_count();
  endtask

  task automatic partial_word();
    spi_word_t   w;
    logic [31:0] data;
    draw_word(w);
    mosi_words.delete();
    mosi_words.push_back(w);
    spi_transfer(9);
    read_reg(`REG_STATUS, data);
    check_status("STATUS partial", '{3'd0, 3'd0, 1'b1, 1'b0, 1'b0}, status_of(data));
    compare_word_count();
  endtask

  task automatic apb_errors();
    spi_word_t   w;
    logic [31:0] data;
    logic        err;
    int          i;
    apb_read(`REG_RXDATA, data, err);
    check_err("pslverr RXDATA empty", 1'b1, err);
    for (i = 0; i < 4; i++) begin
      draw_word(w);
      write_reg(`REG_TXDATA, {16'h0, w});
    end
    apb_write(`REG_TXDATA, 32'h1234, err);
    check_err("pslverr TXDATA full", 1'b1, err);
    apb_read(8'h10, data, err);
    check_err("pslverr offset 0x10", 1'b1, err);
    read_reg(`REG_STATUS, data);
    check_status("STATUS tx full", '{3'd0, 3'd4, 1'b1, 1'b1, 1'b0}, status_of(data));
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    sclk      = SCLK_IDLE;
    mosi      = 1'b0;
    cs        = ~CS_ON;
    apb_req   = '0;
    rng_state = 32'd7;
    words_exp = 16'd0;
    repeat (10) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    reset_values();
    default_reply();
    queued_replies();
    overflow_drop();
    partial_word();
    apb_errors();
    $display("Test completed successfully");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+.
rtl/spi_slave_pkg.sv
rtl/spi_pin_sync.sv
rtl/spi_word_shifter.sv
rtl/sync_fifo.sv
rtl/spi_apb_regs.sv
rtl/spi_slave_top.sv
verification/tb_spi_slave.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the SPI slave testbench with Verilator, run it and judge the log

rm -f sim.log

verilator --binary --timing --assert -Mdir obj_dir --top-module tb_spi_slave -f filelist.f \
  && ./obj_dir/Vtb_spi_slave > sim.log 2>&1 \
  || echo "build or simulation stopped with an error"

grep -q "Test completed successfully" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
